/* verilog/video_config.svh */
`ifndef VIDEO_CONFIG_SVH
`define VIDEO_CONFIG_SVH

// Small raster so that a whole frame runs quickly in simulation

// Horizontal line, counted in pixels
`define H_TOTAL     64
`define H_ACTIVE    48
`define HS_START    52
`define HS_END      55

// Vertical frame, counted in lines
`define V_TOTAL     40
`define V_ACTIVE    32
`define VS_START    35
`define VS_END      36

// System clock cycles per pixel
`define PXL_DIV     4

`endif

/* verilog/video_pkg.sv */
package video_pkg;

typedef logic [5:0]  hpos_t;      // Horizontal count
typedef logic [5:0]  vpos_t;      // Vertical count
typedef logic [11:0] rom_addr_t;  // Graphics ROM word address
typedef logic [15:0] rom_word_t;  // Four pixels, pixel 0 in the low nibble
typedef logic [6:0]  pix_idx_t;   // Colour in [6:4], pixel nibble in [3:0]
typedef logic [14:0] rgb_t;       // 5:5:5 with red on top
typedef logic [6:0]  pal_addr_t;  // CPU palette address

// Raster position and control as made by the timing stage
typedef struct packed {
    hpos_t h;
    vpos_t v;
    logic  hblank;
    logic  vblank;
    logic  hs;
    logic  vs;
} raster_t;

// Palette index with the raster it belongs to
typedef struct packed {
    pix_idx_t idx;
    raster_t  raster;
} pixel_t;

// Graphics ROM request engine
typedef enum logic [1:0] {
    IDLE,       // Nothing fetched yet
    REQ,        // rom_req high, waiting for rom_ack
    WAIT_DROP,  // Data taken, waiting for rom_ack to fall
    HOLD        // Handshake closed, word held in the pending buffer
} fetch_st_e;

endpackage

/* verilog/video_cen.sv */
`timescale 1ns/1ps
`include "video_config.svh"

module video_cen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl_cen,
    output logic pxl2_cen
);

logic [1:0] cnt;    // Free running divider

always_ff @(posedge clk) begin
    if (!rst_n) begin
        cnt      <= '0;
        pxl_cen  <= 1'b0;
        pxl2_cen <= 1'b0;
    end else begin
        cnt      <= cnt + 2'd1;
        pxl2_cen <= cnt[0];                         // clk/2
        pxl_cen  <= cnt == 2'(`PXL_DIV - 1);        // clk/4, lines up with pxl2_cen
    end
end

endmodule

/* verilog/video_timing.sv */
`timescale 1ns/1ps
`include "video_config.svh"

module video_timing import video_pkg::*; (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    pxl_cen,
    output raster_t raster
);

hpos_t h;
vpos_t v;
logic  h_last;
logic  v_last;

assign h_last = h == hpos_t'(`H_TOTAL - 1);
assign v_last = v == vpos_t'(`V_TOTAL - 1);

// Raster counters
always_ff @(posedge clk) begin
    if (!rst_n) begin
        h <= '0;
        v <= '0;
    end else if (pxl_cen) begin
        if (h_last) begin
            h <= '0;
            if (v_last) begin
                v <= '0;
            end else begin
                v <= v + 6'd1;
            end
        end else begin
            h <= h + 6'd1;
        end
    end
end

// Blanking and sync decoded straight from the counters
always_comb begin
    raster.h      = h;
    raster.v      = v;
    raster.hblank = h >= hpos_t'(`H_ACTIVE);
    raster.vblank = v >= vpos_t'(`V_ACTIVE);
    raster.hs     = h >= hpos_t'(`HS_START) && h <= hpos_t'(`HS_END);
    raster.vs     = v >= vpos_t'(`VS_START) && v <= vpos_t'(`VS_END);
end

endmodule

/* verilog/tile_fetch.sv */
`timescale 1ns/1ps
`include "video_config.svh"

module tile_fetch import video_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pxl_cen,
    input  raster_t   raster,
    output rom_addr_t rom_addr,
    output logic      rom_req,
    input  rom_word_t rom_data,
    input  logic      rom_ack,
    output pixel_t    pixel
);

fetch_st_e  state;
rom_addr_t  tgt_addr;   // Group waiting to be requested
logic       want;       // A request is queued
logic       stale;      // Request in flight is for a group already on screen
rom_word_t  pend;       // Word for the next group
logic       pend_ok;
rom_word_t  disp;       // Word for the group on screen
rom_word_t  cur_word;
logic [3:0] nib;
logic [3:0] nxt_grp;
vpos_t      nxt_v;
logic       grp_start;
logic       boundary;
logic       launch;

assign grp_start = raster.h[1:0] == 2'd0;
assign boundary  = pxl_cen && grp_start;
assign rom_req   = state == REQ;

// Hold off one cycle at a boundary so the fresh target is used
assign launch = (state == IDLE || state == HOLD) && want && !rom_ack && !boundary;

// Next group, wrapping into the next line from the last group
always_comb begin
    nxt_grp = raster.h[5:2] + 4'd1;
    nxt_v   = raster.v;
    if (raster.h[5:2] == 4'hF) begin
        nxt_v = (raster.v == vpos_t'(`V_TOTAL - 1)) ? '0 : raster.v + 6'd1;
    end
end

// A late fetch shows as nibble 0 for the whole group
assign cur_word = !grp_start ? disp : (pend_ok ? pend : '0);
assign nib      = cur_word[{raster.h[1:0], 2'b00} +: 4];

always_ff @(posedge clk) begin
    if (!rst_n) begin
        state   <= IDLE;
        want    <= 1'b0;
        stale   <= 1'b0;
        pend_ok <= 1'b0;
    end else begin
        case (state)
            IDLE, HOLD: begin
                if (launch) begin
                    state <= REQ;
                    want  <= 1'b0;
                    stale <= 1'b0;
                end
            end
            REQ: begin
                if (rom_ack) begin
                    pend_ok <= !stale;
                    state   <= WAIT_DROP;
                end
            end
            WAIT_DROP: begin
                if (!rom_ack) begin
                    state <= HOLD;
                end
            end
            default: state <= IDLE;
        endcase
        // Group boundary retires the pending word and queues the next group
        if (boundary) begin
            want    <= 1'b1;
            pend_ok <= 1'b0;
            if (state == REQ) begin
                stale <= 1'b1;
            end
        end
    end
end

always_ff @(posedge clk) begin
    if (state == REQ && rom_ack) pend <= rom_data;
    if (launch) rom_addr <= tgt_addr;     // Stable until the next launch
    if (boundary) tgt_addr <= {2'b00, nxt_v, nxt_grp};
    if (pxl_cen) disp <= cur_word;
end

// One pxl_cen behind the raster
always_ff @(posedge clk) begin
    if (!rst_n) begin
        pixel <= '0;
    end else if (pxl_cen) begin
        pixel.idx    <= {raster.v[5:3], nib};
        pixel.raster <= raster;
    end
end

endmodule

/* verilog/pal_mix.sv */
`timescale 1ns/1ps

module pal_mix import video_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      pxl_cen,
    input  pixel_t    pixel,
    // CPU port
    input  logic      pal_cs,
    input  logic      pal_we,
    input  pal_addr_t pal_addr,
    input  rgb_t      pal_wdata,
    output rgb_t      pal_rdata,
    // Video out
    output rgb_t      rgb,
    output logic      hs,
    output logic      vs,
    output logic      hblank,
    output logic      vblank,
    output hpos_t     hdump,
    output vpos_t     vdump
);

rgb_t pal_mem [0:2**$bits(pal_addr_t)-1];
rgb_t lut_rgb;
logic blank;

// Second read port for the pixel lookup
assign lut_rgb = pal_mem[pixel.idx];
assign blank   = pixel.raster.hblank | pixel.raster.vblank;

// CPU side, write now or read back next cycle
always_ff @(posedge clk) begin
    if (pal_cs) begin
        if (pal_we) begin
            pal_mem[pal_addr] <= pal_wdata;
        end else begin
            pal_rdata <= pal_mem[pal_addr];
        end
    end
end

// Output stage, two pxl_cen behind the counters
always_ff @(posedge clk) begin
    if (!rst_n) begin
        rgb    <= '0;
        hs     <= 1'b0;
        vs     <= 1'b0;
        hblank <= 1'b0;
        vblank <= 1'b0;
        hdump  <= '0;
        vdump  <= '0;
    end else if (pxl_cen) begin
        rgb    <= blank ? '0 : lut_rgb;   // Black outside the active area
        hs     <= pixel.raster.hs;
        vs     <= pixel.raster.vs;
        hblank <= pixel.raster.hblank;
        vblank <= pixel.raster.vblank;
        hdump  <= pixel.raster.h;
        vdump  <= pixel.raster.v;
    end
end

endmodule

/* verilog/video_top.sv */
`timescale 1ns/1ps

module video_top import video_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    output logic      pxl_cen,
    output logic      pxl2_cen,
    // Graphics ROM
    output rom_addr_t rom_addr,
    output logic      rom_req,
    input  rom_word_t rom_data,
    input  logic      rom_ack,
    // CPU palette port
    input  logic      pal_cs,
    input  logic      pal_we,
    input  pal_addr_t pal_addr,
    input  rgb_t      pal_wdata,
    output rgb_t      pal_rdata,
    // Video
    output rgb_t      rgb,
    output logic      hs,
    output logic      vs,
    output logic      hblank,
    output logic      vblank,
    output hpos_t     hdump,
    output vpos_t     vdump
);

raster_t raster;    // Timing to fetch
pixel_t  pixel;     // Fetch to palette

video_cen u_cen (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .pxl_cen  ( pxl_cen  ),
    .pxl2_cen ( pxl2_cen )
);

video_timing u_timing (
    .clk     ( clk     ),
    .rst_n   ( rst_n   ),
    .pxl_cen ( pxl_cen ),
    .raster  ( raster  )
);

tile_fetch u_fetch (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .pxl_cen  ( pxl_cen  ),
    .raster   ( raster   ),
    .rom_addr ( rom_addr ),
    .rom_req  ( rom_req  ),
    .rom_data ( rom_data ),
    .rom_ack  ( rom_ack  ),
    .pixel    ( pixel    )
);

pal_mix u_mix (
    .clk       ( clk       ),
    .rst_n     ( rst_n     ),
    .pxl_cen   ( pxl_cen   ),
    .pixel     ( pixel     ),
    .pal_cs    ( pal_cs    ),
    .pal_we    ( pal_we    ),
    .pal_addr  ( pal_addr  ),
    .pal_wdata ( pal_wdata ),
    .pal_rdata ( pal_rdata ),
    .rgb       ( rgb       ),
    .hs        ( hs        ),
    .vs        ( vs        ),
    .hblank    ( hblank    ),
    .vblank    ( vblank    ),
    .hdump     ( hdump     ),
    .vdump     ( vdump     )
);

endmodule

/* sim/video_chk.sv */
`timescale 1ns/1ps

module video_chk import video_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      rom_req,
    input logic      rom_ack,
    input rom_addr_t rom_addr
);

// New request only once the previous ack has dropped
req_rise_ack_low: assert property (
    @(posedge clk) disable iff (!rst_n)
    $rose(rom_req) |-> !$past(rom_ack)
) else $error("rom_req rose while rom_ack was high");

// Address held for the whole request
addr_stable: assert property (
    @(posedge clk) disable iff (!rst_n)
    rom_req && $past(rom_req) |-> $stable(rom_addr)
) else $error("rom_addr changed while rom_req was high");

req_fall_after_ack: assert property (
    @(posedge clk) disable iff (!rst_n)
    $fell(rom_req) |-> $past(rom_ack)
) else $error("rom_req fell before rom_ack was seen");

endmodule

bind tile_fetch video_chk u_chk (
    .clk      ( clk      ),
    .rst_n    ( rst_n    ),
    .rom_req  ( rom_req  ),
    .rom_ack  ( rom_ack  ),
    .rom_addr ( rom_addr )
);

/* sim/video_tb.sv */
`timescale 1ns/1ps
`include "video_config.svh"

module video_tb import video_pkg::*; ();

localparam int CLK_PERIOD   = 100;
localparam int DRIVE_DLY    = 10;      // Inputs change this long after the rising edge
localparam int RST_CYCLES   = 4;
localparam int N_PAL_ROWS   = 6;
localparam int N_LATE       = 3;
localparam int CHECK_FRAMES = 2;
localparam int FRAME_PIX    = `H_TOTAL * `V_TOTAL;
localparam int FRAME_CLKS   = FRAME_PIX * `PXL_DIV;
localparam int SETUP_CLKS   = 2**$bits(pal_addr_t) + 2 * N_PAL_ROWS;
localparam int LIMIT_CLKS   = RST_CYCLES + SETUP_CLKS + 3 * FRAME_CLKS + 2 * `H_TOTAL * `PXL_DIV;
localparam int unsigned LATE_WAIT = 20;   // Past the 16 clk a group allows

typedef struct packed {
    pal_addr_t addr;
    rgb_t      data;    // Also the value expected back on pal_rdata
} pal_row_t;

logic      clk;
logic      rst_n;
logic      pxl_cen;
logic      pxl2_cen;
rom_addr_t rom_addr;
logic      rom_req;
rom_word_t rom_data;
logic      rom_ack;
logic      pal_cs;
logic      pal_we;
pal_addr_t pal_addr;
rgb_t      pal_wdata;
rgb_t      pal_rdata;
rgb_t      rgb;
logic      hs;
logic      vs;
logic      hblank;
logic      vblank;
hpos_t     hdump;
vpos_t     vdump;

rgb_t        pal_model [0:2**$bits(pal_addr_t)-1];
int unsigned lcg_state = 19412;

pal_row_t pal_tbl [0:N_PAL_ROWS-1] = '{
    '{7'h00, 15'h1234},
    '{7'h10, 15'h7C00},     // Shown by the late group on line 10
    '{7'h1F, 15'h03E0},
    '{7'h2A, 15'h001F},
    '{7'h3F, 15'h7FFF},
    '{7'h55, 15'h2D6B}      // Outside the colours the raster can reach
};

// ROM words answered past the start of their group, as {v, group}
rom_addr_t late_tbl [0:N_LATE-1] = '{12'h0A5, 12'h1BB, 12'h050};

video_top u_dut (.*);

initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
end

function automatic int unsigned lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state >> 16;
endfunction

function automatic rom_word_t rom_rule(rom_addr_t a);
    return {4'h0, a} ^ 16'hA5C3;
endfunction

function automatic rgb_t fill_rgb(pal_addr_t a);
    return {~a[3:0], a, a[3:0]};
endfunction

function automatic logic is_late(rom_addr_t a);
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < N_LATE; i++) begin
        if (late_tbl[i] == a) hit = 1'b1;
    end
    return hit;
endfunction

// Colour the screen should show at a dump position
function automatic rgb_t expect_rgb(hpos_t h, vpos_t v);
    rom_addr_t  a;
    rom_word_t  w;
    logic [3:0] nib;
    if (h >= hpos_t'(`H_ACTIVE) || v >= vpos_t'(`V_ACTIVE)) return '0;
    a   = {2'b00, v, h[5:2]};
    w   = rom_rule(a);
    nib = is_late(a) ? 4'h0 : w[{h[1:0], 2'b00} +: 4];
    return pal_model[{v[5:3], nib}];
endfunction

task automatic abort_run();
    $display("Regression failed");
    $fatal(1, "Run stopped at %0t", $time);
endtask

task automatic check_rgb(string name, rgb_t got, rgb_t exp);
    if (got !== exp) begin
        $display("Error: %s = %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_hpos(string name, hpos_t got, hpos_t exp);
    if (got !== exp) begin
        $display("Error: %s = %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_vpos(string name, vpos_t got, vpos_t exp);
    if (got !== exp) begin
        $display("Error: %s = %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_bit(string name, logic got, logic exp);
    if (got !== exp) begin
        $display("Error: %s = %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic check_count(string name, int got, int exp);
    if (got != exp) begin
        $display("Error: %s = %h, expected %h", name, got, exp);
        abort_run();
    end
endtask

task automatic next_cycle();
    @(posedge clk);
    #DRIVE_DLY;
endtask

// Mid-cycle sample, once per pixel
task automatic wait_pixel();
    @(negedge clk);
    while (!pxl_cen) @(negedge clk);
endtask

task automatic pal_write(pal_addr_t a, rgb_t d);
    pal_cs    = 1'b1;
    pal_we    = 1'b1;
    pal_addr  = a;
    pal_wdata = d;
    next_cycle();
    pal_cs    = 1'b0;
    pal_we    = 1'b0;
    pal_model[a] = d;
endtask

task automatic pal_readback(pal_addr_t a, rgb_t exp);
    pal_cs   = 1'b1;
    pal_addr = a;
    next_cycle();           // Data registered at this edge
    pal_cs   = 1'b0;
    check_rgb("pal_rdata", pal_rdata, exp);
endtask

// Graphics ROM, four-phase responder with random latency
initial begin : rom_model
    int unsigned wait_cyc;
    rom_ack  = 1'b0;
    rom_data = '0;
    forever begin
        next_cycle();
        if (rom_req) begin
            wait_cyc = is_late(rom_addr) ? LATE_WAIT : lcg_next() % 4;
            repeat (wait_cyc) next_cycle();
            rom_data = rom_rule(rom_addr);
            rom_ack  = 1'b1;
            do begin
                next_cycle();
            end while (rom_req);
            repeat (lcg_next() % 4) next_cycle();
            rom_ack = 1'b0;
        end
    end
end

// Divider strobes, pxl_cen every PXL_DIV clk and pxl2_cen every other clk
initial begin : cen_monitor
    int   gap;
    logic prev2;
    wait (rst_n === 1'b1);
    wait_pixel();
    gap   = 0;
    prev2 = pxl2_cen;
    forever begin
        @(negedge clk);
        gap++;
        check_bit("pxl2_cen", pxl2_cen, !prev2);
        prev2 = pxl2_cen;
        check_bit("pxl_cen", pxl_cen, gap == `PXL_DIV);
        if (pxl_cen) gap = 0;
    end
end

initial begin : watchdog
    #(LIMIT_CLKS * CLK_PERIOD);
    $display("Watchdog expired before the video checks finished");
    abort_run();
end

initial begin : main
    hpos_t exp_h;
    vpos_t exp_v;
    int    hs_cnt;
    int    act_cnt;
    int    vs_lines;
    rst_n     = 1'b0;
    pal_cs    = 1'b0;
    pal_we    = 1'b0;
    pal_addr  = '0;
    pal_wdata = '0;
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    check_bit("rom_req", rom_req, 1'b0);    // Still in reset here
    check_bit("hs", hs, 1'b0);
    check_bit("vs", vs, 1'b0);
    check_rgb("rgb", rgb, '0);
    check_bit("pxl_cen", pxl_cen, 1'b0);
    check_bit("pxl2_cen", pxl2_cen, 1'b0);
    check_hpos("hdump", hdump, '0);
    check_vpos("vdump", vdump, '0);
    rst_n = 1'b1;

    for (int a = 0; a < 2**$bits(pal_addr_t); a++) begin
        pal_write(pal_addr_t'(a), fill_rgb(pal_addr_t'(a)));
    end
    for (int i = 0; i < N_PAL_ROWS; i++) begin
        pal_write(pal_tbl[i].addr, pal_tbl[i].data);
        pal_readback(pal_tbl[i].addr, pal_tbl[i].data);
    end

    // Lock onto the next frame start
    wait_pixel();
    while (hdump != '0 || vdump != '0) wait_pixel();
    exp_h    = '0;
    exp_v    = '0;
    hs_cnt   = 0;
    act_cnt  = 0;
    vs_lines = 0;
    for (int n = 0; n <= CHECK_FRAMES * FRAME_PIX; n++) begin
        if (n > 0) wait_pixel();
        check_hpos("hdump", hdump, exp_h);
        check_vpos("vdump", vdump, exp_v);
        check_bit("hblank", hblank, exp_h >= hpos_t'(`H_ACTIVE));
        check_bit("vblank", vblank, exp_v >= vpos_t'(`V_ACTIVE));
        if (n > 0 && exp_h == '0) begin     // Close the line just shown
            check_count("hs pixels per line", hs_cnt, `HS_END - `HS_START + 1);
            check_count("active pixels per line", act_cnt, `H_ACTIVE);
            hs_cnt  = 0;
            act_cnt = 0;
            if (exp_v == '0) begin
                check_count("vs lines per frame", vs_lines, `VS_END - `VS_START + 1);
                vs_lines = 0;
            end
        end
        if (hs) hs_cnt++;
        if (!hblank) act_cnt++;
        if (vs && exp_h == '0) vs_lines++;
        check_rgb($sformatf("rgb at h %0d v %0d", exp_h, exp_v), rgb, expect_rgb(exp_h, exp_v));
        if (exp_h == hpos_t'(`H_TOTAL - 1)) begin
            exp_h = '0;
            exp_v = (exp_v == vpos_t'(`V_TOTAL - 1)) ? '0 : exp_v + 6'd1;
        end else begin
            exp_h = exp_h + 6'd1;
        end
    end
    $display("Regression passed");
    $finish;
end

endmodule

/* vlog.f */
+incdir+verilog
verilog/video_pkg.sv
verilog/video_cen.sv
verilog/video_timing.sv
verilog/tile_fetch.sv
verilog/pal_mix.sv
verilog/video_top.sv
sim/video_chk.sv
sim/video_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module video_tb -f vlog.f -o video_sim
	obj_dir/video_sim 2>&1 | tee sim.log
	! grep -q "Regression failed" sim.log
	grep -q "Regression passed" sim.log

clean:
	rm -rf obj_dir sim.log
